// File: flist.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/pipe_reg.sv
rtl/decoder.sv
rtl/gpr.sv
rtl/forward_unit.sv
rtl/execute.sv
rtl/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: rtl/cpu_top.sv
module cpu_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              inst_valid_i,
  input  isa_pkg::inst_t    inst_i,
  output pipe_pkg::retire_t retire_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  ifid_t           ifid_d;
  ifid_t           ifid_q;
  dec_t            dec;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  idex_t           idex_d;
  idex_t           idex_q;
  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  wb_t             exm1_d;
  wb_t             exm1_q;
  wb_t             m1m2_q;
  wb_t             m2wb_q;

  // ========================================
  // IF
  // ========================================
  // Idle slots carry a NOP so ID never sees stale bits
  assign ifid_d = '{valid: inst_valid_i, inst: inst_valid_i ? inst_i : NOP_INST};

  pipe_reg #(.payload_t(ifid_t)) i_ifid_reg (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (ifid_d),
    .q_o  (ifid_q)
  );

  // ========================================
  // ID
  // ========================================
  decoder i_decoder (
    .inst_i (ifid_q.inst),
    .valid_i(ifid_q.valid),
    .dec_o  (dec)
  );

  // Write port is fed from the end of the pipe
  gpr i_gpr (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rs1_i     (dec.rs1),
    .rs2_i     (dec.rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_i      (m2wb_q)
  );

  assign idex_d = '{dec: dec, rs1_data: rs1_data, rs2_data: rs2_data};

  pipe_reg #(.payload_t(idex_t)) i_idex_reg (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (idex_d),
    .q_o  (idex_q)
  );

  // ========================================
  // EX
  // ========================================
  forward_unit i_forward_unit (
    .ex_i   (idex_q.dec),
    .m1_i   (exm1_q),
    .m2_i   (m1m2_q),
    .wb_i   (m2wb_q),
    .fwd_a_o(fwd_a),
    .fwd_b_o(fwd_b)
  );

  execute i_execute (
    .ex_i   (idex_q),
    .fwd_a_i(fwd_a),
    .fwd_b_i(fwd_b),
    .m1_i   (exm1_q),
    .m2_i   (m1m2_q),
    .wb_i   (m2wb_q),
    .res_o  (exm1_d)
  );

  // ========================================
  // MEM1, MEM2, WB
  // ========================================
  pipe_reg #(.payload_t(wb_t)) i_exm1_reg (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (exm1_d),
    .q_o  (exm1_q)
  );

  // Memory stages hold only the ALU result
  pipe_reg #(.payload_t(wb_t)) i_m1m2_reg (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (exm1_q),
    .q_o  (m1m2_q)
  );

  pipe_reg #(.payload_t(wb_t)) i_m2wb_reg (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .d_i  (m1m2_q),
    .q_o  (m2wb_q)
  );

  assign retire_o = '{valid: m2wb_q.valid, we: m2wb_q.we, rd: m2wb_q.rd, data: m2wb_q.data};

endmodule

// File: rtl/decoder.sv
module decoder (
  input  isa_pkg::inst_t inst_i,
  input  logic           valid_i,
  output pipe_pkg::dec_t dec_o
);
  import isa_pkg::*;

  logic [OPC_W-1:0]      opcode;
  logic [FUNCT3_W-1:0]   funct3;
  logic [FUNCT7_W-1:0]   funct7;
  logic [REG_ADDR_W-1:0] rd;
  logic                  supported;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    dec_o        = '0;
    dec_o.valid  = valid_i;
    dec_o.rs1    = inst_i[19:15];
    dec_o.rs2    = inst_i[24:20];
    dec_o.rd     = rd;
    dec_o.alu_op = ALU_ADD;
    // I-type immediate unless LUI overrides it
    dec_o.imm    = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
    supported    = 1'b1;

    case (opcode)
      OPC_OP_IMM: begin
        dec_o.use_rs1 = 1'b1;
        dec_o.imm_sel = 1'b1;
        case (funct3)
          F3_ADD_SUB: dec_o.alu_op = ALU_ADD;
          F3_SLT:     dec_o.alu_op = ALU_SLT;
          F3_XOR:     dec_o.alu_op = ALU_XOR;
          F3_OR:      dec_o.alu_op = ALU_OR;
          F3_AND:     dec_o.alu_op = ALU_AND;
          default:    supported = 1'b0;
        endcase
      end
      OPC_OP: begin
        dec_o.use_rs1 = 1'b1;
        dec_o.use_rs2 = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: dec_o.alu_op = ALU_ADD;
          {F7_ALT, F3_ADD_SUB}:  dec_o.alu_op = ALU_SUB;
          {F7_BASE, F3_SLL}:     dec_o.alu_op = ALU_SLL;
          {F7_BASE, F3_SLT}:     dec_o.alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}:     dec_o.alu_op = ALU_XOR;
          {F7_BASE, F3_SRL_SRA}: dec_o.alu_op = ALU_SRL;
          {F7_ALT, F3_SRL_SRA}:  dec_o.alu_op = ALU_SRA;
          {F7_BASE, F3_OR}:      dec_o.alu_op = ALU_OR;
          {F7_BASE, F3_AND}:     dec_o.alu_op = ALU_AND;
          default:               supported = 1'b0;
        endcase
      end
      OPC_LUI: begin
        dec_o.imm_sel = 1'b1;
        dec_o.imm     = {inst_i[31:12], 12'b0};
        dec_o.alu_op  = ALU_PASS_B;
      end
      default: supported = 1'b0;
    endcase

    // Unknown encodings still flow down the pipe as harmless bubbles
    if (!supported) begin
      dec_o.use_rs1 = 1'b0;
      dec_o.use_rs2 = 1'b0;
    end
    dec_o.we = valid_i && supported && (rd != '0);
  end

endmodule

// File: rtl/execute.sv
module execute (
  input  pipe_pkg::idex_t    ex_i,
  input  pipe_pkg::fwd_sel_e fwd_a_i,
  input  pipe_pkg::fwd_sel_e fwd_b_i,
  input  pipe_pkg::wb_t      m1_i,
  input  pipe_pkg::wb_t      m2_i,
  input  pipe_pkg::wb_t      wb_i,
  output pipe_pkg::wb_t      res_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0]    src_a;
  logic [XLEN-1:0]    src_b;
  logic [XLEN-1:0]    op_b;
  logic [XLEN-1:0]    alu_out;
  logic [SHAMT_W-1:0] shamt;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [XLEN-1:0] reg_val);
    case (sel)
      FWD_M1:  return m1_i.data;
      FWD_M2:  return m2_i.data;
      FWD_WB:  return wb_i.data;
      default: return reg_val;
    endcase
  endfunction

  // ========================================
  // Operand select
  // ========================================
  always_comb begin
    src_a = fwd_mux(fwd_a_i, ex_i.rs1_data);
    src_b = fwd_mux(fwd_b_i, ex_i.rs2_data);
    op_b  = ex_i.dec.imm_sel ? ex_i.dec.imm : src_b;
  end

  assign shamt = op_b[SHAMT_W-1:0];

  // ========================================
  // ALU
  // ========================================
  always_comb begin
    case (ex_i.dec.alu_op)
      ALU_ADD:    alu_out = src_a + op_b;
      ALU_SUB:    alu_out = src_a - op_b;
      ALU_SLL:    alu_out = src_a << shamt;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
      ALU_XOR:    alu_out = src_a ^ op_b;
      ALU_SRL:    alu_out = src_a >> shamt;
      ALU_SRA:    alu_out = $unsigned($signed(src_a) >>> shamt);
      ALU_OR:     alu_out = src_a | op_b;
      ALU_AND:    alu_out = src_a & op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = '0;
    endcase
  end

  always_comb begin
    res_o.valid = ex_i.dec.valid;
    res_o.we    = ex_i.dec.we;
    res_o.rd    = ex_i.dec.rd;
    res_o.data  = alu_out;
  end

endmodule

// File: rtl/forward_unit.sv
module forward_unit (
  input  pipe_pkg::dec_t     ex_i,
  input  pipe_pkg::wb_t      m1_i,
  input  pipe_pkg::wb_t      m2_i,
  input  pipe_pkg::wb_t      wb_i,
  output pipe_pkg::fwd_sel_e fwd_a_o,
  output pipe_pkg::fwd_sel_e fwd_b_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  function automatic logic hit(input wb_t stage, input logic [REG_ADDR_W-1:0] idx);
    return stage.valid && stage.we && (stage.rd != '0) && (stage.rd == idx);
  endfunction

  // Youngest producer wins
  function automatic fwd_sel_e pick(input logic en, input logic [REG_ADDR_W-1:0] idx);
    if (!en) return FWD_NONE;
    if (hit(m1_i, idx)) return FWD_M1;
    if (hit(m2_i, idx)) return FWD_M2;
    if (hit(wb_i, idx)) return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb begin
    fwd_a_o = pick(ex_i.valid && ex_i.use_rs1, ex_i.rs1);
    fwd_b_o = pick(ex_i.valid && ex_i.use_rs2, ex_i.rs2);
  end

endmodule

// File: rtl/gpr.sv
module gpr (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [isa_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [isa_pkg::XLEN-1:0]       rs1_data_o,
  output logic [isa_pkg::XLEN-1:0]       rs2_data_o,
  input  pipe_pkg::wb_t                  wr_i
);
  import isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];
  logic            wr_en;

  assign wr_en = wr_i.valid && wr_i.we && (wr_i.rd != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_i.rd] <= wr_i.data;
    end
  end

  // Same-cycle write is visible to ID, which covers distance four
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] idx);
    if (idx == '0) return '0;
    if (wr_en && (wr_i.rd == idx)) return wr_i.data;
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_i);
    rs2_data_o = read_port(rs2_i);
  end

endmodule

// File: rtl/isa_pkg.sv
package isa_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int INST_W     = 32;
  localparam int NUM_REGS   = 32;
  localparam int OPC_W      = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;
  localparam int SHAMT_W    = 5;

  typedef logic [INST_W-1:0] inst_t;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // ========================================
  // Encodings
  // ========================================
  localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;

  localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

  // SUB and SRA use the alternate funct7
  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

endpackage

// File: rtl/pipe_pkg.sv
package pipe_pkg;

  // Operand source seen from EX
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_M1,
    FWD_M2,
    FWD_WB
  } fwd_sel_e;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    logic           valid;
    isa_pkg::inst_t inst;
  } ifid_t;

  typedef struct packed {
    logic                             valid;
    logic                             we;
    logic [isa_pkg::REG_ADDR_W-1:0]   rs1;
    logic [isa_pkg::REG_ADDR_W-1:0]   rs2;
    logic                             use_rs1;
    logic                             use_rs2;
    logic [isa_pkg::REG_ADDR_W-1:0]   rd;
    isa_pkg::alu_op_e                 alu_op;
    logic                             imm_sel;
    logic [isa_pkg::XLEN-1:0]         imm;
  } dec_t;

  typedef struct packed {
    dec_t                     dec;
    logic [isa_pkg::XLEN-1:0] rs1_data;
    logic [isa_pkg::XLEN-1:0] rs2_data;
  } idex_t;

  // Result record from EX onward
  typedef struct packed {
    logic                           valid;
    logic                           we;
    logic [isa_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    logic                           valid;
    logic                           we;
    logic [isa_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::XLEN-1:0]       data;
  } retire_t;

endpackage

// File: rtl/pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // No stall, so the stage advances every cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      q_o <= '0;
    end else begin
      q_o <= d_i;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f flist.f --top-module cpu_tb -o cpu_sim
result=$(./obj_dir/cpu_sim 2>&1) || true
printf '%s\n' "$result"
echo "$result" | grep -q "Test completed successfully"

// File: tests/cpu_checker.sv
module cpu_checker (
  input logic              clk_i,
  input logic              rst_i,
  input logic              inst_valid_i,
  input pipe_pkg::retire_t retire_i
);

  localparam int LATENCY = 5;

  // Cycles since reset, saturating once the pipe is full
  logic [2:0] since_rst;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      since_rst <= '0;
    end else if (since_rst != 3'd5) begin
      since_rst <= since_rst + 3'd1;
    end
  end

  // ========================================
  // Retire protocol
  // ========================================
  a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
    (since_rst < 3'd5) |-> !retire_i.valid)
    else $error("retire valid before the pipe could hold an instruction");

  a_fixed_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    (since_rst == 3'd5) |-> (retire_i.valid == $past(inst_valid_i, LATENCY)))
    else $error("retire valid does not follow inst_valid_i by five cycles");

  a_we_has_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_i.we |-> (retire_i.valid && (retire_i.rd != '0)))
    else $error("retire we without valid or with rd of zero");

endmodule

// File: tests/cpu_stimulus.txt
// test valid inst we rd data, all hex, one instruction slot per line
// valid 0 is an idle slot; a test number of 0 ends the stream
1 0 00000000 0 00 00000000
1 0 00000000 0 00 00000000
1 1 12300093 1 01 00000123
1 1 fff00113 1 02 ffffffff
2 1 800001b7 1 03 80000000
2 1 00500213 1 04 00000005
2 1 00112293 1 05 00000001
2 1 0ff0c313 1 06 000001dc
2 1 4000e393 1 07 00000523
2 1 0f017413 1 08 000000f0
2 1 004095b3 1 0b 00002460
2 1 0041a633 1 0c 00000001
2 1 003226b3 1 0d 00000000
2 1 0041d7b3 1 0f 04000000
2 1 4041d833 1 10 fc000000
2 1 0040e8b3 1 11 00000127
2 1 00117933 1 12 00000123
3 1 01000a13 1 14 00000010
3 1 014a0ab3 1 15 00000020
3 1 414a8b33 1 16 00000010
3 1 015a4bb3 1 17 00000030
3 1 001a0c13 1 18 00000011
3 1 00700c93 1 19 00000007
3 1 00900c93 1 19 00000009
3 1 019c8d33 1 1a 00000012
4 1 05508013 0 00 00000000
4 1 00100db3 1 1b 00000123
4 1 abcde037 0 00 00000000
4 1 00106e13 1 1c 00000001
5 1 02100e93 1 1d 00000021
5 0 00000000 0 00 00000000
5 0 00000000 0 00 00000000
5 1 001e8e93 1 1d 00000022
5 0 00000000 0 00 00000000
5 1 002e8f13 1 1e 00000024
6 1 0000a083 0 01 00000000
6 1 021080b3 0 01 00000000
6 1 00008f93 1 1f 00000123
0 0 00000000 0 00 00000000

// File: tests/cpu_tb.sv
module cpu_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int MAX_LINES     = 64;
  localparam int FIELDS        = 6;
  localparam int LATENCY       = 5;
  localparam int DRAIN_TIMEOUT = 20;

  // Expected retire record and the cycle it is due
  typedef struct packed {
    logic [7:0]  test;
    logic [31:0] due;
    retire_t     rec;
  } expect_t;

  logic    clk_i;
  logic    rst_i;
  logic    inst_valid_i;
  inst_t   inst_i;
  retire_t retire_o;

  logic [31:0] stim_mem [0:MAX_LINES*FIELDS-1];
  logic [31:0] cycle_cnt = '0;
  expect_t     exp_q [$];
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  cpu_top i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .inst_valid_i(inst_valid_i),
    .inst_i      (inst_i),
    .retire_o    (retire_o)
  );

  bind cpu_top cpu_checker i_checker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .inst_valid_i(inst_valid_i),
    .retire_i    (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ========================================
  // Retire monitor
  // ========================================
  task automatic check_retire(input expect_t head);
    if (cycle_cnt != head.due) begin
      $display("Test %0d: rd %h retired at cycle %0d instead of cycle %0d",
               head.test, retire_o.rd, cycle_cnt, head.due);
      err_cnt++;
    end
    if (retire_o.we !== head.rec.we) begin
      $display("FAILED test %0d: retire_o.we expected %h got %h",
               head.test, head.rec.we, retire_o.we);
      err_cnt++;
    end
    if (retire_o.rd !== head.rec.rd) begin
      $display("FAILED test %0d: retire_o.rd expected %h got %h",
               head.test, head.rec.rd, retire_o.rd);
      err_cnt++;
    end
    // Result only matters when a register is written
    if (head.rec.we && (retire_o.data !== head.rec.data)) begin
      $display("FAILED test %0d: retire_o.data expected %h got %h",
               head.test, head.rec.data, retire_o.data);
      err_cnt++;
    end
  endtask

  // Away from the edge where retire_o changes
  always @(negedge clk_i) begin
    if (!rst_i && retire_o.valid) begin
      if (exp_q.size() == 0) begin
        $display("Retire of rd %h seen with no instruction in flight", retire_o.rd);
        err_cnt++;
      end else begin
        check_retire(exp_q.pop_front());
      end
    end
  end

  // ========================================
  // Stimulus
  // ========================================
  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      inst_valid_i = 1'b0;
      inst_i       = '0;
    end
  endtask

  task automatic drive_line(input int base);
    expect_t item;
    @(posedge clk_i);
    #1;
    inst_valid_i = stim_mem[base+1][0];
    inst_i       = stim_mem[base+2];
    if (stim_mem[base+1][0]) begin
      item.test      = stim_mem[base][7:0];
      item.due       = cycle_cnt + LATENCY;
      item.rec.valid = 1'b1;
      item.rec.we    = stim_mem[base+3][0];
      item.rec.rd    = stim_mem[base+4][4:0];
      item.rec.data  = stim_mem[base+5];
      exp_q.push_back(item);
    end
  endtask

  // Drain the pipe, then report the test
  task automatic finish_test(input int num, input int err_base);
    int   wait_cnt;
    logic timed_out;
    drive_idle(1);
    wait_cnt = 0;
    while ((exp_q.size() != 0) && (wait_cnt < DRAIN_TIMEOUT)) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    timed_out = (exp_q.size() != 0);
    if (timed_out) begin
      $display("Test %0d: %0d instructions never retired", num, exp_q.size());
      exp_q.delete();
    end
    if (timed_out || (err_cnt != err_base)) begin
      fail_cnt++;
      $display("Test %0d: not passed, %0d errors", num, err_cnt - err_base);
    end else begin
      pass_cnt++;
      $display("Test %0d: passed", num);
    end
  endtask

  initial begin
    int i;
    int rec_idx;
    int base;
    int cur_test;
    int err_base;
    int idle;
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    void'($urandom(32'h647ce1de));
    for (i = 0; i < MAX_LINES * FIELDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("tests/cpu_stimulus.txt", stim_mem);

    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    cur_test = 0;
    err_base = 0;
    for (rec_idx = 0; rec_idx < MAX_LINES; rec_idx++) begin
      base = rec_idx * FIELDS;
      if (stim_mem[base] == 0) begin
        break;
      end
      if (stim_mem[base] != cur_test) begin
        if (cur_test != 0) begin
          finish_test(cur_test, err_base);
        end
        idle = $urandom % 4;
        drive_idle(idle);
        cur_test = stim_mem[base];
        err_base = err_cnt;
      end
      drive_line(base);
    end
    if (cur_test != 0) begin
      finish_test(cur_test, err_base);
    end
    drive_idle(2);

    if (pass_cnt + fail_cnt == 0) begin
      $display("No test records found in the stimulus file");
    end
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if ((fail_cnt == 0) && (pass_cnt > 0) && (err_cnt == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
